//--- rtl/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    parameter int XLEN      = 32;
    parameter int MBE_WIDTH = XLEN / 8;    // one enable per byte lane

    // low three bits are the RV32I funct3, bit 3 set for stores
    typedef enum logic [3:0] {
        lb  = 4'b0000,
        lh  = 4'b0001,
        lw  = 4'b0010,
        lbu = 4'b0100,
        lhu = 4'b0101,
        sb  = 4'b1000,
        sh  = 4'b1001,
        sw  = 4'b1010
    } mem_op_t;

    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } access_size_t;

endpackage : lsu_pkg

`default_nettype wire

//--- rtl/lsu_decode.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_decode #(
    parameter int ADDR_WIDTH = 32
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       req_valid,
    input  lsu_pkg::mem_op_t           req_op,
    input  logic [ADDR_WIDTH-1:0]      req_addr,
    input  logic [lsu_pkg::XLEN-1:0]   req_wdata,
    input  logic                       done,
    output logic                       busy,
    output logic                       dec_valid,
    output lsu_pkg::access_size_t      dec_size,
    output logic                       dec_unsigned,
    output logic                       dec_write,
    output logic [ADDR_WIDTH-1:0]      dec_addr,
    output logic [lsu_pkg::XLEN-1:0]   dec_wdata
);

    logic             busy_q;
    logic             accept;
    lsu_pkg::mem_op_t op_q;

    assign busy   = busy_q & ~done;    // free again in the done cycle
    assign accept = req_valid & ~busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q    <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= accept;
            if (accept) begin
                busy_q <= 1'b1;    // back-to-back accept wins over done
            end else if (done) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q      <= req_op;
            dec_addr  <= req_addr;
            dec_wdata <= req_wdata;
        end
    end

    // split the held op into size, sign and direction
    always_comb begin
        dec_size     = lsu_pkg::size_word;
        dec_unsigned = 1'b0;
        dec_write    = 1'b0;
        case (op_q)
            lsu_pkg::lb:  dec_size = lsu_pkg::size_byte;
            lsu_pkg::lh:  dec_size = lsu_pkg::size_half;
            lsu_pkg::lw:  dec_size = lsu_pkg::size_word;
            lsu_pkg::lbu: begin
                dec_size     = lsu_pkg::size_byte;
                dec_unsigned = 1'b1;
            end
            lsu_pkg::lhu: begin
                dec_size     = lsu_pkg::size_half;
                dec_unsigned = 1'b1;
            end
            lsu_pkg::sb: begin
                dec_size  = lsu_pkg::size_byte;
                dec_write = 1'b1;
            end
            lsu_pkg::sh: begin
                dec_size  = lsu_pkg::size_half;
                dec_write = 1'b1;
            end
            lsu_pkg::sw: begin
                dec_size  = lsu_pkg::size_word;
                dec_write = 1'b1;
            end
            default: ;
        endcase
    end

endmodule : lsu_decode

`default_nettype wire

//--- rtl/lsu_execute.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_execute #(
    parameter int ADDR_WIDTH = 32
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            dec_valid,
    input  lsu_pkg::access_size_t           dec_size,
    input  logic                            dec_unsigned,
    input  logic                            dec_write,
    input  logic [ADDR_WIDTH-1:0]           dec_addr,
    input  logic [lsu_pkg::XLEN-1:0]        dec_wdata,
    input  logic                            data_mem_resp,
    output logic                            data_read,
    output logic                            data_write,
    output logic [ADDR_WIDTH-1:0]           data_mem_address,
    output logic [lsu_pkg::MBE_WIDTH-1:0]   data_mbe,
    output logic [lsu_pkg::XLEN-1:0]        data_mem_wdata,
    output logic                            mem_done,
    output logic                            mem_is_load,
    output logic [lsu_pkg::MBE_WIDTH-1:0]   mem_mbe,
    output lsu_pkg::access_size_t           mem_size,
    output logic                            mem_unsigned
);

    logic [lsu_pkg::MBE_WIDTH-1:0] mbe_next;
    logic [lsu_pkg::XLEN-1:0]      wdata_next;
    logic                          active;

    assign active  = data_read | data_write;
    assign mem_mbe = data_mbe;    // lane info for the load extractor

    // byte enables from size and low address bits
    always_comb begin
        mbe_next = '0;
        case (dec_size)
            lsu_pkg::size_byte: begin
                case (dec_addr[1:0])
                    2'b00:   mbe_next = 4'b0001;
                    2'b01:   mbe_next = 4'b0010;
                    2'b10:   mbe_next = 4'b0100;
                    default: mbe_next = 4'b1000;
                endcase
            end
            lsu_pkg::size_half: begin
                mbe_next = dec_addr[1] ? 4'b1100 : 4'b0011;    // bit 0 ignored
            end
            lsu_pkg::size_word: mbe_next = 4'b1111;
            default: ;
        endcase
    end

    // move the low byte or half into the enabled lanes
    always_comb begin
        wdata_next = '0;
        case (mbe_next)
            4'b0001: wdata_next = {24'b0, dec_wdata[7:0]};
            4'b0010: wdata_next = {16'b0, dec_wdata[7:0], 8'b0};
            4'b0100: wdata_next = {8'b0, dec_wdata[7:0], 16'b0};
            4'b1000: wdata_next = {dec_wdata[7:0], 24'b0};
            4'b0011: wdata_next = {16'b0, dec_wdata[15:0]};
            4'b1100: wdata_next = {dec_wdata[15:0], 16'b0};
            4'b1111: wdata_next = dec_wdata;
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_read  <= 1'b0;
            data_write <= 1'b0;
            data_mbe   <= '0;
            mem_done   <= 1'b0;
        end else begin
            mem_done <= active & data_mem_resp;    // one cycle after the response
            if (dec_valid) begin
                data_read  <= ~dec_write;
                data_write <= dec_write;
                data_mbe   <= mbe_next;
            end else if (active && data_mem_resp) begin
                data_read  <= 1'b0;    // levels drop after the response
                data_write <= 1'b0;
            end
        end
    end

    // payload held stable for the whole access
    always_ff @(posedge clk) begin
        if (dec_valid) begin
            data_mem_address <= {dec_addr[ADDR_WIDTH-1:2], 2'b00};
            data_mem_wdata   <= wdata_next;
            mem_is_load      <= ~dec_write;
            mem_size         <= dec_size;
            mem_unsigned     <= dec_unsigned;
        end
    end

endmodule : lsu_execute

`default_nettype wire

//--- rtl/lsu_result.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_result (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            mem_done,
    input  logic                            mem_is_load,
    input  logic [lsu_pkg::MBE_WIDTH-1:0]   mem_mbe,
    input  lsu_pkg::access_size_t           mem_size,
    input  logic                            mem_unsigned,
    input  logic [lsu_pkg::XLEN-1:0]        data_mem_rdata,
    output logic                            done,
    output logic [lsu_pkg::XLEN-1:0]        load_data
);

    logic [lsu_pkg::XLEN-1:0] rdata_q;
    logic [7:0]               byte_lane;
    logic [15:0]              half_lane;
    logic [lsu_pkg::XLEN-1:0] load_next;

    // holds the response word while mem_done is high
    always_ff @(posedge clk) begin
        rdata_q <= data_mem_rdata;
    end

    // pick the enabled lane
    always_comb begin
        byte_lane = rdata_q[7:0];
        half_lane = rdata_q[15:0];
        case (mem_mbe)
            4'b0010: byte_lane = rdata_q[15:8];
            4'b0100: byte_lane = rdata_q[23:16];
            4'b1000: byte_lane = rdata_q[31:24];
            4'b1100: half_lane = rdata_q[31:16];
            default: ;
        endcase
    end

    always_comb begin
        load_next = rdata_q;    // word loads pass as is
        case (mem_size)
            lsu_pkg::size_byte: begin
                load_next = {{(lsu_pkg::XLEN-8){byte_lane[7] & ~mem_unsigned}}, byte_lane};
            end
            lsu_pkg::size_half: begin
                load_next = {{(lsu_pkg::XLEN-16){half_lane[15] & ~mem_unsigned}}, half_lane};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done      <= 1'b0;
            load_data <= '0;
        end else begin
            done <= mem_done;    // stores finish here too
            if (mem_done && mem_is_load) begin
                load_data <= load_next;
            end
        end
    end

endmodule : lsu_result

`default_nettype wire

//--- rtl/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
    parameter int ADDR_WIDTH = 32
) (
    input  logic                            clk,
    input  logic                            rst_n,

    // requester side
    input  logic                            req_valid,
    input  lsu_pkg::mem_op_t                req_op,
    input  logic [ADDR_WIDTH-1:0]           req_addr,
    input  logic [lsu_pkg::XLEN-1:0]        req_wdata,
    output logic                            busy,
    output logic                            done,
    output logic [lsu_pkg::XLEN-1:0]        load_data,

    // data memory side
    output logic                            data_read,
    output logic                            data_write,
    output logic [ADDR_WIDTH-1:0]           data_mem_address,
    output logic [lsu_pkg::MBE_WIDTH-1:0]   data_mbe,
    output logic [lsu_pkg::XLEN-1:0]        data_mem_wdata,
    input  logic [lsu_pkg::XLEN-1:0]        data_mem_rdata,
    input  logic                            data_mem_resp
);

    logic                          dec_valid;
    lsu_pkg::access_size_t         dec_size;
    logic                          dec_unsigned;
    logic                          dec_write;
    logic [ADDR_WIDTH-1:0]         dec_addr;
    logic [lsu_pkg::XLEN-1:0]      dec_wdata;

    logic                          mem_done;
    logic                          mem_is_load;
    logic [lsu_pkg::MBE_WIDTH-1:0] mem_mbe;
    lsu_pkg::access_size_t         mem_size;
    logic                          mem_unsigned;

    lsu_decode #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) lsu_decode_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req_op      (req_op),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .done        (done),    // releases busy
        .busy        (busy),
        .dec_valid   (dec_valid),
        .dec_size    (dec_size),
        .dec_unsigned(dec_unsigned),
        .dec_write   (dec_write),
        .dec_addr    (dec_addr),
        .dec_wdata   (dec_wdata)
    );

    lsu_execute #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) lsu_execute_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .dec_valid       (dec_valid),
        .dec_size        (dec_size),
        .dec_unsigned    (dec_unsigned),
        .dec_write       (dec_write),
        .dec_addr        (dec_addr),
        .dec_wdata       (dec_wdata),
        .data_mem_resp   (data_mem_resp),
        .data_read       (data_read),
        .data_write      (data_write),
        .data_mem_address(data_mem_address),
        .data_mbe        (data_mbe),
        .data_mem_wdata  (data_mem_wdata),
        .mem_done        (mem_done),
        .mem_is_load     (mem_is_load),
        .mem_mbe         (mem_mbe),
        .mem_size        (mem_size),
        .mem_unsigned    (mem_unsigned)
    );

    lsu_result lsu_result_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_done      (mem_done),
        .mem_is_load   (mem_is_load),
        .mem_mbe       (mem_mbe),
        .mem_size      (mem_size),
        .mem_unsigned  (mem_unsigned),
        .data_mem_rdata(data_mem_rdata),    // straight from memory
        .done          (done),
        .load_data     (load_data)
    );

endmodule : lsu_top

`default_nettype wire

//--- verif/lsu_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_asserts #(
    parameter int ADDR_WIDTH = 32
) (
    input wire logic                            clk,
    input wire logic                            rst_n,
    input wire logic                            data_read,
    input wire logic                            data_write,
    input wire logic [ADDR_WIDTH-1:0]           data_mem_address,
    input wire logic [lsu_pkg::MBE_WIDTH-1:0]   data_mbe,
    input wire logic [lsu_pkg::XLEN-1:0]        data_mem_wdata,
    input wire logic                            data_mem_resp,
    input wire logic                            done
);

    a_one_direction: assert property (@(posedge clk) disable iff (!rst_n)
        !(data_read && data_write))
        else $error("data_read and data_write high together");

    // request held until the memory answers
    a_hold_until_resp: assert property (@(posedge clk) disable iff (!rst_n)
        (data_read || data_write) && !data_mem_resp |=>
            $stable(data_read) && $stable(data_write) && $stable(data_mem_address)
            && $stable(data_mbe) && $stable(data_mem_wdata))
        else $error("memory request changed before the response");

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else $error("done held for more than one cycle");

endmodule : lsu_asserts

bind lsu_top lsu_asserts #(
    .ADDR_WIDTH(ADDR_WIDTH)
) lsu_asserts_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .data_read       (data_read),
    .data_write      (data_write),
    .data_mem_address(data_mem_address),
    .data_mbe        (data_mbe),
    .data_mem_wdata  (data_mem_wdata),
    .data_mem_resp   (data_mem_resp),
    .done            (done)
);

`default_nettype wire

//--- verif/tb_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsu;

    localparam int ADDR_WIDTH     = 32;
    localparam int N_REQUESTS     = 33 + 300;    // directed plus random
    localparam int TIMEOUT_CYCLES = N_REQUESTS * 12 + 50;

    logic                          clk;
    logic                          rst_n;
    logic                          req_valid;
    lsu_pkg::mem_op_t              req_op;
    logic [ADDR_WIDTH-1:0]         req_addr;
    logic [lsu_pkg::XLEN-1:0]      req_wdata;
    logic                          busy;
    logic                          done;
    logic [lsu_pkg::XLEN-1:0]      load_data;
    logic                          data_read;
    logic                          data_write;
    logic [ADDR_WIDTH-1:0]         data_mem_address;
    logic [lsu_pkg::MBE_WIDTH-1:0] data_mbe;
    logic [lsu_pkg::XLEN-1:0]      data_mem_wdata;
    logic [lsu_pkg::XLEN-1:0]      data_mem_rdata;
    logic                          data_mem_resp;

    logic [lsu_pkg::XLEN-1:0] mem     [64];    // written through the DUT's enables
    logic [lsu_pkg::XLEN-1:0] ref_mem [64];    // written from the lane rules
    logic [lsu_pkg::XLEN-1:0] last_load;
    int errors         = 0;
    int accepted_count = 0;
    int done_count     = 0;
    int access_count   = 0;

    lsu_top #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) lsu_top_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .req_valid       (req_valid),
        .req_op          (req_op),
        .req_addr        (req_addr),
        .req_wdata       (req_wdata),
        .busy            (busy),
        .done            (done),
        .load_data       (load_data),
        .data_read       (data_read),
        .data_write      (data_write),
        .data_mem_address(data_mem_address),
        .data_mbe        (data_mbe),
        .data_mem_wdata  (data_mem_wdata),
        .data_mem_rdata  (data_mem_rdata),
        .data_mem_resp   (data_mem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_word(input string name, input logic [lsu_pkg::XLEN-1:0] expected,
                              input logic [lsu_pkg::XLEN-1:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_mbe(input string name, input logic [lsu_pkg::MBE_WIDTH-1:0] expected,
                             input logic [lsu_pkg::MBE_WIDTH-1:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %b got %b", $time, name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %b got %b", $time, name, expected, actual);
        end
    endtask

    function automatic logic [lsu_pkg::XLEN-1:0] fill_word(input int i);
        return {8'(i), 8'(i * 7 + 3), ~8'(i), 8'(i ^ 8'h5a)};
    endfunction

    function automatic lsu_pkg::mem_op_t random_op();
        case ($urandom_range(7, 0))
            0:       return lsu_pkg::lb;
            1:       return lsu_pkg::lh;
            2:       return lsu_pkg::lw;
            3:       return lsu_pkg::lbu;
            4:       return lsu_pkg::lhu;
            5:       return lsu_pkg::sb;
            6:       return lsu_pkg::sh;
            default: return lsu_pkg::sw;
        endcase
    endfunction

    // funct3 bits 1:0 give the size
    function automatic logic [lsu_pkg::MBE_WIDTH-1:0] expect_mbe(input lsu_pkg::mem_op_t op,
                                                                input logic [1:0] lo);
        case (op[1:0])
            2'b00:   return 4'b0001 << lo;
            2'b01:   return lo[1] ? 4'b1100 : 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic logic [lsu_pkg::XLEN-1:0] expect_wdata(input lsu_pkg::mem_op_t op,
                                                             input logic [1:0] lo,
                                                             input logic [lsu_pkg::XLEN-1:0] wd);
        case (op[1:0])
            2'b00:   return {24'b0, wd[7:0]} << (8 * lo);
            2'b01:   return {16'b0, wd[15:0]} << (lo[1] ? 16 : 0);
            default: return wd;
        endcase
    endfunction

    function automatic void apply_store(input lsu_pkg::mem_op_t op,
                                        input logic [ADDR_WIDTH-1:0] addr,
                                        input logic [lsu_pkg::XLEN-1:0] wd);
        logic [lsu_pkg::MBE_WIDTH-1:0] m;
        logic [lsu_pkg::XLEN-1:0]      v;
        m = expect_mbe(op, addr[1:0]);
        v = expect_wdata(op, addr[1:0], wd);
        for (int k = 0; k < lsu_pkg::MBE_WIDTH; k++) begin
            if (m[k]) ref_mem[addr[7:2]][8*k +: 8] = v[8*k +: 8];
        end
    endfunction

    // bit 2 of funct3 marks the unsigned loads
    function automatic logic [lsu_pkg::XLEN-1:0] expect_load(input lsu_pkg::mem_op_t op,
                                                            input logic [ADDR_WIDTH-1:0] addr);
        logic [lsu_pkg::XLEN-1:0] word;
        logic [7:0]               b;
        logic [15:0]              h;
        word = ref_mem[addr[7:2]];
        b    = word[8 * int'(addr[1:0]) +: 8];
        h    = addr[1] ? word[31:16] : word[15:0];
        case (op[1:0])
            2'b00:   return op[2] ? {24'b0, b} : {{24{b[7]}}, b};
            2'b01:   return op[2] ? {16'b0, h} : {{16{h[15]}}, h};
            default: return word;
        endcase
    endfunction

    // issue one request, check the memory side, then wait for done
    task automatic run_access(input lsu_pkg::mem_op_t op, input logic [ADDR_WIDTH-1:0] addr,
                              input logic [lsu_pkg::XLEN-1:0] wd, input bit noisy);
        logic [lsu_pkg::MBE_WIDTH-1:0] exp_mbe;
        logic [lsu_pkg::XLEN-1:0]      exp_wdata;
        logic [lsu_pkg::XLEN-1:0]      exp_load;
        bit                            seen_level;
        bit                            finished;
        exp_mbe    = expect_mbe(op, addr[1:0]);
        exp_wdata  = expect_wdata(op, addr[1:0], wd);
        exp_load   = last_load;    // stores leave it alone
        seen_level = 1'b0;
        finished   = 1'b0;
        while (busy) begin
            @(posedge clk);
            #2;
        end
        req_valid = 1'b1;
        req_op    = op;
        req_addr  = addr;
        req_wdata = wd;
        @(posedge clk);
        #2;
        req_valid = 1'b0;
        if (op[3]) apply_store(op, addr, wd);
        else exp_load = expect_load(op, addr);
        while (!finished) begin
            @(posedge clk);
            #1;
            check_flag("busy", !done, busy);    // low only in the done cycle
            if (!seen_level && (data_read || data_write)) begin
                seen_level = 1'b1;
                check_flag("data_write", op[3], data_write);
                check_flag("data_read", ~op[3], data_read);
                check_word("data_mem_address", {addr[ADDR_WIDTH-1:2], 2'b00}, data_mem_address);
                check_mbe("data_mbe", exp_mbe, data_mbe);
                if (op[3]) check_word("data_mem_wdata", exp_wdata, data_mem_wdata);
            end
            if (done) begin
                finished = 1'b1;
                if (!seen_level) begin
                    errors++;
                    $display("done pulse at %0t came without any memory access", $time);
                end
                check_word("load_data", exp_load, load_data);
                last_load = exp_load;
            end
            #1;
            if (!finished && noisy && busy && $urandom_range(3, 0) == 0) begin
                req_valid = 1'b1;    // must be dropped
                req_op    = random_op();
                req_addr  = $urandom;
                req_wdata = $urandom;
            end else begin
                req_valid = 1'b0;
            end
        end
    endtask

    // memory answers after 0 to 3 cycles and checks the request stays put
    initial begin : memory_model
        int unsigned               delay;
        logic [5:0]                idx;
        logic                      was_write;
        logic [ADDR_WIDTH-1:0]     addr_hold;
        logic [lsu_pkg::MBE_WIDTH-1:0] mbe_hold;
        logic [lsu_pkg::XLEN-1:0]  wdata_hold;
        data_mem_resp  = 1'b0;
        data_mem_rdata = '0;
        forever begin
            @(posedge clk);
            #1;
            if (rst_n && (data_read || data_write)) begin
                access_count++;
                was_write  = data_write;
                addr_hold  = data_mem_address;
                mbe_hold   = data_mbe;
                wdata_hold = data_mem_wdata;
                delay      = $urandom_range(3, 0);
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                    check_flag("data_write", was_write, data_write);
                    check_flag("data_read", ~was_write, data_read);
                    check_word("data_mem_address", addr_hold, data_mem_address);
                    check_mbe("data_mbe", mbe_hold, data_mbe);
                    check_word("data_mem_wdata", wdata_hold, data_mem_wdata);
                end
                idx = data_mem_address[7:2];
                if (data_write) begin
                    for (int k = 0; k < lsu_pkg::MBE_WIDTH; k++) begin
                        if (data_mbe[k]) mem[idx][8*k +: 8] = data_mem_wdata[8*k +: 8];
                    end
                end
                #1;
                data_mem_rdata = data_write ? $urandom : mem[idx];
                data_mem_resp  = 1'b1;
                @(posedge clk);
                #2;
                data_mem_resp  = 1'b0;
                data_mem_rdata = $urandom;    // stale data must not leak through
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            if (req_valid && !busy) accepted_count++;
            if (done) done_count++;
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    initial begin : main
        int unsigned           seed_val;
        logic [ADDR_WIDTH-1:0] base;
        lsu_pkg::mem_op_t      store_ops [3];
        lsu_pkg::mem_op_t      load_ops  [5];
        seed_val  = $urandom(16);
        store_ops = '{lsu_pkg::sb, lsu_pkg::sh, lsu_pkg::sw};
        load_ops  = '{lsu_pkg::lb, lsu_pkg::lbu, lsu_pkg::lh, lsu_pkg::lhu, lsu_pkg::lw};
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_op    = lsu_pkg::lb;
        req_addr  = '0;
        req_wdata = '0;
        last_load = '0;
        for (int i = 0; i < 64; i++) begin
            mem[i]     = fill_word(i);
            ref_mem[i] = fill_word(i);
        end
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;
        check_flag("busy", 1'b0, busy);
        check_flag("done", 1'b0, done);
        check_flag("data_read", 1'b0, data_read);
        check_flag("data_write", 1'b0, data_write);
        check_mbe("data_mbe", '0, data_mbe);
        check_word("load_data", '0, load_data);

        // every store size at every byte offset
        for (int s = 0; s < 3; s++) begin
            for (int lo = 0; lo < 4; lo++) begin
                base = $urandom;
                run_access(store_ops[s], {base[ADDR_WIDTH-1:2], 2'(lo)}, $urandom, 1'b0);
            end
        end

        // one known word, then every load kind at every lane
        base = $urandom;
        base[1:0] = 2'b00;
        run_access(lsu_pkg::sw, base, $urandom, 1'b0);
        for (int l = 0; l < 5; l++) begin
            for (int lo = 0; lo < 4; lo++) begin
                run_access(load_ops[l], {base[ADDR_WIDTH-1:2], 2'(lo)}, $urandom, 1'b0);
            end
        end

        repeat (300) begin
            run_access(random_op(), $urandom, $urandom, 1'b1);
        end

        repeat (2) @(posedge clk);
        if (accepted_count != N_REQUESTS || access_count != N_REQUESTS) begin
            errors++;
            $display("expected %0d requests, saw %0d accepted and %0d memory accesses",
                     N_REQUESTS, accepted_count, access_count);
        end
        if (done_count != accepted_count) begin
            errors++;
            $display("done pulses (%0d) do not match accepted requests (%0d)",
                     done_count, accepted_count);
        end
        $display("errors: %0d  accepted: %0d  done: %0d  accesses: %0d",
                 errors, accepted_count, done_count, access_count);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : tb_lsu

`default_nettype wire

//--- filelist.f
rtl/lsu_pkg.sv
rtl/lsu_decode.sv
rtl/lsu_execute.sv
rtl/lsu_result.sv
rtl/lsu_top.sv
verif/lsu_asserts.sv
verif/tb_lsu.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_lsu -Mdir obj_dir -f filelist.f
	./obj_dir/Vtb_lsu > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Finished with errors" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
